// File: bench/decodeReference.svh
`ifndef decodeReferenceSvh
`define decodeReferenceSvh

// Expected control word packed MSB first
// regSeq[26:24] regAAddr[23:22] regBAddr[21:19] aluOp[18:15]
// cclLoad[14] aluASrc[13:11] aluBSrc[10:8] argA[7:4] argB[3:0]
function automatic logic [26:0] expectedControls(input logic [15:0] word);
	logic [2:0] seq;
	logic [1:0] aAddr;
	logic [2:0] bAddr;
	logic [3:0] op;
	logic       ccl;
	logic [2:0] aSrc;
	logic [2:0] bSrc;
	if (word[15:14] != forthDecodePkg::groupAluLogic) begin
		return '0; // Idle word has every field zero
	end
	op    = word[13:10];
	ccl   = (op != forthDecodePkg::aluMov); // MOV keeps the flags
	aSrc  = forthDecodePkg::aSrcRegA;
	aAddr = word[5:4];
	bAddr = 3'd0;
	case (word[9:8])
		2'd0: begin
			seq   = forthDecodePkg::seqLdaRdb; // Reg-reg
			bAddr = word[2:0];
			bSrc  = forthDecodePkg::bSrcRegB;
		end
		2'd1: begin
			seq  = forthDecodePkg::seqLdaImm;
			bSrc = forthDecodePkg::bSrcU4;
		end
		2'd2: begin
			seq   = forthDecodePkg::seqLdaImm;
			aAddr = 2'd0; // Byte modes work on R0
			bSrc  = forthDecodePkg::bSrcU8;
		end
		default: begin
			seq   = forthDecodePkg::seqLdaImm;
			aAddr = 2'd0;
			bSrc  = forthDecodePkg::bSrcS8;
		end
	endcase
	return {seq, aAddr, bAddr, op, ccl, aSrc, bSrc, word[7:4], word[3:0]};
endfunction

`endif

// File: bench/forthDecodeBench.sv
`timescale 1ns/1ps
`default_nettype none

module forthDecodeBench;

	localparam int randomCount  = 200;
	localparam int foreignPairs = 30;
	// Reset, stalled cycling, directed, random, foreign groups, hold test
	localparam int plannedCycles = 4 + 8 * 16 + 4 * 4 + randomCount * 4
		+ foreignPairs * 8 + 16;

	logic clk = 1'b0;
	logic reset;
	logic pcEnable;
	logic [15:0] din;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;
	logic [15:0] instruction;
	forthDecodePkg::regSeqT  regSeq;
	logic [1:0]              regAAddr;
	logic [2:0]              regBAddr;
	forthDecodePkg::aluOpT   aluOp;
	logic                    cclLoad;
	forthDecodePkg::aluASrcT aluASrc;
	forthDecodePkg::aluBSrcT aluBSrc;
	logic [3:0]              argA;
	logic [3:0]              argB;

	int errorCount = 0;
	int checkCount = 0;
	int testErrors = 0;
	logic [31:0] lcgState;
	logic [1:0]  modelPhase; // Bench copy of the sequencer
	logic [15:0] modelInstr;
	logic [26:0] modelCtrl;

	forthDecodeUnit dut (
		.clk(clk), .reset(reset), .pcEnable(pcEnable), .din(din),
		.fetch(fetch), .decode(decode), .execute(execute), .commit(commit),
		.instruction(instruction), .regSeq(regSeq), .regAAddr(regAAddr),
		.regBAddr(regBAddr), .aluOp(aluOp), .cclLoad(cclLoad),
		.aluASrc(aluASrc), .aluBSrc(aluBSrc), .argA(argA), .argB(argB)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic logic [26:0] dutControls();
		return {regSeq, regAAddr, regBAddr, aluOp, cclLoad, aluASrc, aluBSrc, argA, argB};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error at %0d ns: %s expected %0h actual %0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic stepEdge();
		@(posedge clk);
		#2;
	endtask

	// One instruction through all four phases with optional random stalls
	task automatic issueInstruction(input logic [15:0] word, input int maxStall);
		int stall;
		for (int p = 0; p < 4; p++) begin
			if (maxStall > 0) begin
				stall = int'(nextRandom() >> 16) % (maxStall + 1);
				pcEnable = 1'b0;
				repeat (stall) stepEdge();
			end
			din      = word;
			pcEnable = 1'b1;
			stepEdge();
		end
	endtask

	task automatic finishTest(input string name);
		$display("test %s done, %0d errors", name, errorCount - testErrors);
		testErrors = errorCount;
	endtask

	// Compare process sampling the values just before each edge
	always @(posedge clk) begin
		if (reset) begin
			modelPhase = 2'd0;
			modelInstr = '0;
			modelCtrl  = '0;
		end else begin
			checkValue("fetch", 32'(modelPhase == 2'd0), 32'(fetch));
			checkValue("decode", 32'(modelPhase == 2'd1), 32'(decode));
			checkValue("execute", 32'(modelPhase == 2'd2), 32'(execute));
			checkValue("commit", 32'(modelPhase == 2'd3), 32'(commit));
			checkValue("instruction", 32'(modelInstr), 32'(instruction));
			checkValue("regSeq", 32'(modelCtrl[26:24]), 32'(regSeq));
			checkValue("regAAddr", 32'(modelCtrl[23:22]), 32'(regAAddr));
			checkValue("regBAddr", 32'(modelCtrl[21:19]), 32'(regBAddr));
			checkValue("aluOp", 32'(modelCtrl[18:15]), 32'(aluOp));
			checkValue("cclLoad", 32'(modelCtrl[14]), 32'(cclLoad));
			checkValue("aluASrc", 32'(modelCtrl[13:11]), 32'(aluASrc));
			checkValue("aluBSrc", 32'(modelCtrl[10:8]), 32'(aluBSrc));
			checkValue("argA", 32'(modelCtrl[7:4]), 32'(argA));
			checkValue("argB", 32'(modelCtrl[3:0]), 32'(argB));
			if (pcEnable) begin
				if (modelPhase == 2'd0) modelInstr = din;
				if (modelPhase == 2'd1) modelCtrl = expectedControls(modelInstr);
				modelPhase = modelPhase + 2'd1; // COMMIT wraps to FETCH
			end
		end
	end

	initial begin
		#(plannedCycles * 40 + 400);
		$display("watchdog expired, the tests did not end within %0d cycles", plannedCycles);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		logic [15:0] word;
		logic [15:0] prevWord;
		reset    = 1'b1;
		pcEnable = 1'b0;
		din      = '0;
		lcgState = 32'h2b7b41d9;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		checkValue("fetch", 32'd1, 32'(fetch));
		checkValue("controls", 32'd0, 32'(dutControls()));
		stepEdge(); // Idle hold with pcEnable low
		finishTest("reset state");

		for (int i = 0; i < 8; i++) begin
			rnd  = nextRandom();
			word = {forthDecodePkg::groupAluLogic, rnd[29:16]};
			issueInstruction(word, 3);
		end
		finishTest("phase cycling");

		issueInstruction(16'h5835, 0); // AND reg-reg
		issueInstruction(16'h592a, 0); // AND reg-U4
		issueInstruction(16'h5ac3, 0); // AND U8
		issueInstruction(16'h479e, 0); // MOV S8 without flag load
		finishTest("directed modes");

		for (int i = 0; i < randomCount; i++) begin
			rnd = nextRandom();
			issueInstruction({forthDecodePkg::groupAluLogic, rnd[29:16]}, 0);
		end
		finishTest("random alu group");

		// Each foreign word follows an ALU word so the idle load is visible
		for (int i = 0; i < foreignPairs; i++) begin
			rnd = nextRandom();
			issueInstruction({forthDecodePkg::groupAluLogic, rnd[13:0]}, 0);
			word = rnd[31:16];
			if (word[15:14] == forthDecodePkg::groupAluLogic) word[15:14] = 2'b11;
			issueInstruction(word, 0);
		end
		finishTest("non-alu groups");

		prevWord = 16'h5835;
		word     = 16'h4a17;
		issueInstruction(prevWord, 0);
		checkValue("controls", 32'(expectedControls(prevWord)), 32'(dutControls()));
		din      = word;
		pcEnable = 1'b1;
		stepEdge(); // DECODE of the next word
		checkValue("controls", 32'(expectedControls(prevWord)), 32'(dutControls()));
		pcEnable = 1'b0;
		repeat (3) stepEdge();
		checkValue("controls", 32'(expectedControls(prevWord)), 32'(dutControls()));
		pcEnable = 1'b1;
		stepEdge(); // EXECUTE brings the new controls
		checkValue("controls", 32'(expectedControls(word)), 32'(dutControls()));
		repeat (2) stepEdge();
		pcEnable = 1'b0;
		stepEdge();
		finishTest("hold across fetch");

		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	`include "decodeReference.svh"

endmodule

`default_nettype wire

// File: forthDecode.f
+incdir+bench
logic/forthDecodePkg.sv
logic/phaseSequencer.sv
logic/aluGroupDecoder.sv
logic/operandDecoder.sv
logic/controlLatch.sv
logic/forthDecodeUnit.sv
bench/forthDecodeBench.sv

// File: logic/aluGroupDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module aluGroupDecoder (
	input  wire logic [forthDecodePkg::instrWidth-1:0] instruction,
	output forthDecodePkg::aluOpT   nextAluOp,
	output forthDecodePkg::aluASrcT nextASrc,
	output forthDecodePkg::aluBSrcT nextBSrc,
	output logic                    nextCclLoad
);

	forthDecodePkg::aluOpT   op;
	forthDecodePkg::aluModeT mode;

	// Fields straight from the latched word
	assign op   = forthDecodePkg::aluOpT'(
		instruction[forthDecodePkg::opHi:forthDecodePkg::opLo]);
	assign mode = forthDecodePkg::aluModeT'(
		instruction[forthDecodePkg::modeHi:forthDecodePkg::modeLo]);

	always_comb begin
		nextAluOp = op; // Spare codes go through unchanged
		nextASrc  = forthDecodePkg::aSrcRegA;

		// Mode only steers the B side
		case (mode)
			forthDecodePkg::modeRegReg: begin
				nextBSrc = forthDecodePkg::bSrcRegB;
			end
			forthDecodePkg::modeRegU4: begin
				nextBSrc = forthDecodePkg::bSrcU4;
			end
			forthDecodePkg::modeRegAU8: begin
				nextBSrc = forthDecodePkg::bSrcU8;
			end
			forthDecodePkg::modeRegAS8: begin
				nextBSrc = forthDecodePkg::bSrcS8;
			end
			default: begin
				nextBSrc = forthDecodePkg::bSrcNone;
			end
		endcase

		// MOV leaves the flags alone
		nextCclLoad = (op != forthDecodePkg::aluMov);
	end

endmodule

`default_nettype wire

// File: logic/controlLatch.sv
`timescale 1ns/1ps
`default_nettype none

module controlLatch (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic pcEnable,
	input  wire logic decode,
	input  wire logic [1:0] group,
	input  wire forthDecodePkg::regSeqT  nextRegSeq,
	input  wire logic [1:0]              nextRegAAddr,
	input  wire logic [2:0]              nextRegBAddr,
	input  wire forthDecodePkg::aluOpT   nextAluOp,
	input  wire logic                    nextCclLoad,
	input  wire forthDecodePkg::aluASrcT nextASrc,
	input  wire forthDecodePkg::aluBSrcT nextBSrc,
	input  wire logic [3:0]              nextArgA,
	input  wire logic [3:0]              nextArgB,
	output forthDecodePkg::regSeqT  regSeq,
	output logic [1:0]              regAAddr,
	output logic [2:0]              regBAddr,
	output forthDecodePkg::aluOpT   aluOp,
	output logic                    cclLoad,
	output forthDecodePkg::aluASrcT aluASrc,
	output forthDecodePkg::aluBSrcT aluBSrc,
	output logic [3:0]              argA,
	output logic [3:0]              argB
);

	logic loadEn;
	logic isAlu;

	assign loadEn = pcEnable && decode; // Edge leaving DECODE
	assign isAlu  = (group == forthDecodePkg::groupAluLogic);

	always_ff @(posedge clk) begin
		if (reset || (loadEn && !isAlu)) begin
			// Idle word also used for every non-ALU group
			regSeq   <= forthDecodePkg::seqNone;
			regAAddr <= '0;
			regBAddr <= '0;
			aluOp    <= forthDecodePkg::aluNop;
			cclLoad  <= 1'b0;
			aluASrc  <= forthDecodePkg::aSrcNone;
			aluBSrc  <= forthDecodePkg::bSrcNone;
			argA     <= '0;
			argB     <= '0;
		end else if (loadEn) begin
			regSeq   <= nextRegSeq;
			regAAddr <= nextRegAAddr;
			regBAddr <= nextRegBAddr;
			aluOp    <= nextAluOp;
			cclLoad  <= nextCclLoad;
			aluASrc  <= nextASrc;
			aluBSrc  <= nextBSrc;
			argA     <= nextArgA;
			argB     <= nextArgB;
		end
	end

endmodule

`default_nettype wire

// File: logic/forthDecodePkg.sv
`default_nettype none

package forthDecodePkg;

	// Instruction word
	localparam int instrWidth = 16;

	// Field positions within the instruction
	localparam int groupHi = 15;
	localparam int groupLo = 14;
	localparam int opHi    = 13;
	localparam int opLo    = 10;
	localparam int modeHi  = 9;
	localparam int modeLo  = 8;

	// Operand byte subfields
	localparam int argAHi  = 7;
	localparam int argALo  = 4;
	localparam int argBHi  = 3;
	localparam int argBLo  = 0;
	localparam int regAHi  = 5; // A register inside the high nibble
	localparam int regALo  = 4;
	localparam int regBHi  = 2; // B register inside the low nibble
	localparam int regBLo  = 0;

	// Arithmetic/logic group code
	localparam logic [1:0] groupAluLogic = 2'b01;

	typedef enum logic [1:0] {
		phaseFetch   = 2'd0,
		phaseDecode  = 2'd1,
		phaseExecute = 2'd2,
		phaseCommit  = 2'd3
	} phaseT;

	// Full 4-bit space so any operation field casts cleanly
	typedef enum logic [3:0] {
		aluNop    = 4'h0,
		aluMov    = 4'h1,
		aluAdd    = 4'h2,
		aluAdc    = 4'h3,
		aluSub    = 4'h4,
		aluSbc    = 4'h5,
		aluAnd    = 4'h6,
		aluOr     = 4'h7,
		aluXor    = 4'h8,
		aluInv    = 4'h9,
		aluShl    = 4'ha,
		aluShr    = 4'hb,
		aluRol    = 4'hc,
		aluRor    = 4'hd,
		aluSpareE = 4'he,
		aluSpareF = 4'hf
	} aluOpT;

	typedef enum logic [1:0] {
		modeRegReg = 2'd0, // A reg, B reg
		modeRegU4  = 2'd1, // A reg, B 4-bit immediate
		modeRegAU8 = 2'd2, // R0 with unsigned byte
		modeRegAS8 = 2'd3  // R0 with signed byte
	} aluModeT;

	typedef enum logic [2:0] {
		aSrcNone = 3'd0,
		aSrcRegA = 3'd1
	} aluASrcT;

	typedef enum logic [2:0] {
		bSrcNone = 3'd0,
		bSrcRegB = 3'd1,
		bSrcU4   = 3'd2,
		bSrcU8   = 3'd3,
		bSrcS8   = 3'd4
	} aluBSrcT;

	// Register file read sequences
	typedef enum logic [2:0] {
		seqNone   = 3'd0,
		seqLdaRdb = 3'd1,
		seqLdaImm = 3'd2
	} regSeqT;

endpackage

`default_nettype wire

// File: logic/forthDecodeUnit.sv
`timescale 1ns/1ps
`default_nettype none

module forthDecodeUnit (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic pcEnable,
	input  wire logic [forthDecodePkg::instrWidth-1:0] din,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic [forthDecodePkg::instrWidth-1:0] instruction,
	output forthDecodePkg::regSeqT  regSeq,
	output logic [1:0]              regAAddr,
	output logic [2:0]              regBAddr,
	output forthDecodePkg::aluOpT   aluOp,
	output logic                    cclLoad,
	output forthDecodePkg::aluASrcT aluASrc,
	output forthDecodePkg::aluBSrcT aluBSrc,
	output logic [3:0]              argA,
	output logic [3:0]              argB
);

	// Combinational decode results
	forthDecodePkg::aluOpT   nextAluOp;
	forthDecodePkg::aluASrcT nextASrc;
	forthDecodePkg::aluBSrcT nextBSrc;
	logic                    nextCclLoad;
	forthDecodePkg::regSeqT  nextRegSeq;
	logic [1:0]              nextRegAAddr;
	logic [2:0]              nextRegBAddr;
	logic [3:0]              nextArgA;
	logic [3:0]              nextArgB;

	phaseSequencer sequencer (
		.clk        (clk),
		.reset      (reset),
		.pcEnable   (pcEnable),
		.din        (din),
		.fetch      (fetch),
		.decode     (decode),
		.execute    (execute),
		.commit     (commit),
		.instruction(instruction)
	);

	aluGroupDecoder aluDecoder (
		.instruction(instruction),
		.nextAluOp  (nextAluOp),
		.nextASrc   (nextASrc),
		.nextBSrc   (nextBSrc),
		.nextCclLoad(nextCclLoad)
	);

	operandDecoder argDecoder (
		.instruction (instruction),
		.nextRegSeq  (nextRegSeq),
		.nextRegAAddr(nextRegAAddr),
		.nextRegBAddr(nextRegBAddr),
		.nextArgA    (nextArgA),
		.nextArgB    (nextArgB)
	);

	controlLatch latch (
		.clk         (clk),
		.reset       (reset),
		.pcEnable    (pcEnable),
		.decode      (decode),
		.group       (instruction[forthDecodePkg::groupHi:forthDecodePkg::groupLo]),
		.nextRegSeq  (nextRegSeq),
		.nextRegAAddr(nextRegAAddr),
		.nextRegBAddr(nextRegBAddr),
		.nextAluOp   (nextAluOp),
		.nextCclLoad (nextCclLoad),
		.nextASrc    (nextASrc),
		.nextBSrc    (nextBSrc),
		.nextArgA    (nextArgA),
		.nextArgB    (nextArgB),
		.regSeq      (regSeq),
		.regAAddr    (regAAddr),
		.regBAddr    (regBAddr),
		.aluOp       (aluOp),
		.cclLoad     (cclLoad),
		.aluASrc     (aluASrc),
		.aluBSrc     (aluBSrc),
		.argA        (argA),
		.argB        (argB)
	);

endmodule

`default_nettype wire

// File: logic/operandDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module operandDecoder (
	input  wire logic [forthDecodePkg::instrWidth-1:0] instruction,
	output forthDecodePkg::regSeqT nextRegSeq,
	output logic [1:0]             nextRegAAddr,
	output logic [2:0]             nextRegBAddr,
	output logic [3:0]             nextArgA,
	output logic [3:0]             nextArgB
);

	forthDecodePkg::aluModeT mode;
	logic [1:0]              regAField;
	logic [2:0]              regBField;

	assign mode = forthDecodePkg::aluModeT'(
		instruction[forthDecodePkg::modeHi:forthDecodePkg::modeLo]);

	// Register fields out of the operand byte
	assign regAField = instruction[forthDecodePkg::regAHi:forthDecodePkg::regALo];
	assign regBField = instruction[forthDecodePkg::regBHi:forthDecodePkg::regBLo];

	always_comb begin
		nextRegSeq   = forthDecodePkg::seqNone;
		nextRegAAddr = '0;
		nextRegBAddr = '0;

		case (mode)
			forthDecodePkg::modeRegReg: begin
				// Both operands from the register file
				nextRegSeq   = forthDecodePkg::seqLdaRdb;
				nextRegAAddr = regAField;
				nextRegBAddr = regBField;
			end
			forthDecodePkg::modeRegU4: begin
				nextRegSeq   = forthDecodePkg::seqLdaImm; // B is the low nibble
				nextRegAAddr = regAField;
			end
			forthDecodePkg::modeRegAU8,
			forthDecodePkg::modeRegAS8: begin
				// Whole byte is the immediate with A fixed at R0
				nextRegSeq   = forthDecodePkg::seqLdaImm;
				nextRegAAddr = 2'd0;
			end
		endcase
	end

	// Nibbles always travel as arguments
	assign nextArgA = instruction[forthDecodePkg::argAHi:forthDecodePkg::argALo];
	assign nextArgB = instruction[forthDecodePkg::argBHi:forthDecodePkg::argBLo];

endmodule

`default_nettype wire

// File: logic/phaseSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer (
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic pcEnable,
	input  wire logic [forthDecodePkg::instrWidth-1:0] din,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit,
	output logic [forthDecodePkg::instrWidth-1:0] instruction
);

	forthDecodePkg::phaseT phase;

	always_ff @(posedge clk) begin
		if (reset) begin
			phase       <= forthDecodePkg::phaseFetch;
			instruction <= '0;
		end else if (pcEnable) begin
			case (phase)
				forthDecodePkg::phaseFetch: begin
					phase       <= forthDecodePkg::phaseDecode;
					instruction <= din; // Capture on the way out of FETCH
				end
				forthDecodePkg::phaseDecode: begin
					phase <= forthDecodePkg::phaseExecute;
				end
				forthDecodePkg::phaseExecute: begin
					phase <= forthDecodePkg::phaseCommit;
				end
				default: begin
					phase <= forthDecodePkg::phaseFetch; // COMMIT wraps
				end
			endcase
		end
	end

	// One-hot phase levels
	assign fetch   = (phase == forthDecodePkg::phaseFetch);
	assign decode  = (phase == forthDecodePkg::phaseDecode);
	assign execute = (phase == forthDecodePkg::phaseExecute);
	assign commit  = (phase == forthDecodePkg::phaseCommit);

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Build and run the decode front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	--top-module forthDecodeBench \
	-f forthDecode.f \
	-o forthDecodeSim

output=$(./obj_dir/forthDecodeSim)
echo "$output"

if echo "$output" | grep -qxF "Finished with no errors"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
